// ==== hdl/rv_pkg.sv ====
package rv_pkg;

  localparam int xlen     = 32;
  localparam int pc_width = 16;

  ////////////////////////////////////////////////////////////////////////////
  // Opcodes and ALU operations
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,
    opc_op_imm = 7'b0010011,
    opc_lui    = 7'b0110111,
    opc_branch = 7'b1100011,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add    = 4'd0,
    alu_sub    = 4'd1,
    alu_and    = 4'd2,
    alu_or     = 4'd3,
    alu_xor    = 4'd4,
    alu_slt    = 4'd5,
    alu_sll    = 4'd6,
    alu_srl    = 4'd7,
    alu_pass_b = 4'd8
  } alu_op_e;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction formats, msb first
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_e     opcode;
  } i_fmt_t;

  // S and B share the register fields, B scrambles the offset
  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    opcode_e    opcode;
  } b_fmt_t;

  // J reuses the same 20 upper bits in a different order
  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    opcode_e     opcode;
  } u_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
  } instr_u;

  ////////////////////////////////////////////////////////////////////////////
  // Port and stage records
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    instr_u              instr;
    logic [pc_width-1:0] pc;
  } instr_in_t;

  typedef struct packed {
    logic                valid;
    logic                illegal;
    logic [pc_width-1:0] pc;
    logic [4:0]          rs1;
    logic [4:0]          rs2;
    logic [4:0]          rd;
    logic [xlen-1:0]     rs1_data;
    logic [xlen-1:0]     rs2_data;
    logic [xlen-1:0]     imm;
    alu_op_e             alu_op;
    logic                alu_src_imm;
    logic                reg_write;
    logic                branch;
    logic [2:0]          branch_cond;
    logic                jal;
    logic                jalr;
    logic                lui;
  } dec_ex_t;

  typedef struct packed {
    logic                valid;
    logic                illegal;
    logic [pc_width-1:0] pc;
    logic [4:0]          rd;
    logic                reg_write;
    logic [xlen-1:0]     result;
  } ex_wb_t;

  typedef struct packed {
    logic                valid;
    logic [pc_width-1:0] target;
  } redirect_t;

  typedef struct packed {
    logic                valid;
    logic                illegal;
    logic [pc_width-1:0] pc;
    logic [4:0]          rd;
    logic                reg_write;
    logic [xlen-1:0]     result;
  } retire_t;

endpackage

// ==== hdl/reg_file.sv ====
`timescale 1ns/100ps

module reg_file (
  input  logic                    bus,
  input  logic                    reset,
  input  logic [4:0]              raddr1,
  input  logic [4:0]              raddr2,
  input  logic                    we,
  input  logic [4:0]              waddr,
  input  logic [rv_pkg::xlen-1:0] wdata,
  output logic [rv_pkg::xlen-1:0] rdata1,
  output logic [rv_pkg::xlen-1:0] rdata2
);

  // x0 has no storage
  logic [rv_pkg::xlen-1:0] regs [1:31];

  // Same-cycle write is passed straight through
  function automatic logic [rv_pkg::xlen-1:0] read_port(input logic [4:0] addr);
    if (addr == 5'd0) begin
      return '0;
    end
    if (we && waddr == addr) begin
      return wdata;
    end
    return regs[addr];
  endfunction

  always_comb begin
    rdata1 = read_port(raddr1);
    rdata2 = read_port(raddr2);
  end

  always_ff @(posedge bus) begin
    // No writes while the core sits in reset
    if (!reset && we && waddr != 5'd0) begin
      regs[waddr] <= wdata;
    end
  end

endmodule

// ==== hdl/decode_stage.sv ====
`timescale 1ns/100ps

module decode_stage (
  input  logic                    bus,
  input  logic                    reset,
  input  rv_pkg::instr_in_t       in,
  input  logic                    in_valid,
  input  rv_pkg::redirect_t       flush,
  input  logic [rv_pkg::xlen-1:0] rdata1,
  input  logic [rv_pkg::xlen-1:0] rdata2,
  output logic                    in_ready,
  output logic [4:0]              raddr1,
  output logic [4:0]              raddr2,
  output rv_pkg::dec_ex_t         dec_ex
);

  logic                    ready_q;
  logic                    fire;
  logic                    hold_valid;
  rv_pkg::instr_in_t       hold;
  rv_pkg::instr_u          ins;
  rv_pkg::dec_ex_t         dec_next;
  logic [19:0]             j_bits;
  logic [rv_pkg::xlen-1:0] imm_i;
  logic [rv_pkg::xlen-1:0] imm_b;
  logic [rv_pkg::xlen-1:0] imm_u;
  logic [rv_pkg::xlen-1:0] imm_j;

  assign in_ready = ready_q;
  assign fire     = in_valid && ready_q;

  //////////////////////////////////////////////////////////////////////////
  // Instruction holding register
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (reset) begin
      ready_q    <= 1'b0;
      hold_valid <= 1'b0;
    end else begin
      ready_q    <= 1'b1;
      // Word taken during a redirect is dropped
      hold_valid <= fire && !flush.valid;
    end
  end

  always_ff @(posedge bus) begin
    if (fire) begin
      hold <= in;
    end
  end

  assign ins    = hold.instr;
  assign raddr1 = ins.r_fmt.rs1;
  assign raddr2 = ins.r_fmt.rs2;

  // Immediates for each format
  assign j_bits = ins.u_fmt.imm_31_12;
  assign imm_i  = {{20{ins.i_fmt.imm_11_0[11]}}, ins.i_fmt.imm_11_0};
  assign imm_b  = {{19{ins.b_fmt.imm_12}}, ins.b_fmt.imm_12, ins.b_fmt.imm_11,
                   ins.b_fmt.imm_10_5, ins.b_fmt.imm_4_1, 1'b0};
  assign imm_u  = {ins.u_fmt.imm_31_12, 12'h000};
  assign imm_j  = {{11{j_bits[19]}}, j_bits[19], j_bits[7:0], j_bits[8], j_bits[18:9], 1'b0};

  //////////////////////////////////////////////////////////////////////////
  // Control generation
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    dec_next             = '0;
    dec_next.valid       = hold_valid;
    dec_next.pc          = hold.pc;
    dec_next.rs1         = ins.r_fmt.rs1;
    dec_next.rs2         = ins.r_fmt.rs2;
    dec_next.rd          = ins.r_fmt.rd;
    dec_next.rs1_data    = rdata1;
    dec_next.rs2_data    = rdata2;
    dec_next.alu_op      = rv_pkg::alu_add;
    dec_next.branch_cond = ins.b_fmt.funct3;

    case (ins.r_fmt.opcode)
      rv_pkg::opc_op: begin
        dec_next.reg_write = 1'b1;
        case (ins.r_fmt.funct3)
          3'b000: begin
            if (ins.r_fmt.funct7[5]) begin
              dec_next.alu_op = rv_pkg::alu_sub;
            end else begin
              dec_next.alu_op = rv_pkg::alu_add;
            end
          end
          3'b001:  dec_next.alu_op = rv_pkg::alu_sll;
          3'b010:  dec_next.alu_op = rv_pkg::alu_slt;
          3'b100:  dec_next.alu_op = rv_pkg::alu_xor;
          3'b101:  dec_next.alu_op = rv_pkg::alu_srl;
          3'b110:  dec_next.alu_op = rv_pkg::alu_or;
          3'b111:  dec_next.alu_op = rv_pkg::alu_and;
          default: dec_next.illegal = 1'b1;
        endcase
        // funct7 is zero except 0x20 for sub
        if (ins.r_fmt.funct7 != 7'b0000000 &&
            !(ins.r_fmt.funct7 == 7'b0100000 && ins.r_fmt.funct3 == 3'b000)) begin
          dec_next.illegal = 1'b1;
        end
      end
      rv_pkg::opc_op_imm: begin
        dec_next.reg_write   = 1'b1;
        dec_next.alu_src_imm = 1'b1;
        dec_next.imm         = imm_i;
        case (ins.i_fmt.funct3)
          3'b000:  dec_next.alu_op = rv_pkg::alu_add;
          3'b010:  dec_next.alu_op = rv_pkg::alu_slt;
          3'b100:  dec_next.alu_op = rv_pkg::alu_xor;
          3'b110:  dec_next.alu_op = rv_pkg::alu_or;
          3'b111:  dec_next.alu_op = rv_pkg::alu_and;
          default: dec_next.illegal = 1'b1;
        endcase
      end
      rv_pkg::opc_lui: begin
        dec_next.reg_write   = 1'b1;
        dec_next.alu_src_imm = 1'b1;
        dec_next.lui         = 1'b1;
        dec_next.imm         = imm_u;
        dec_next.alu_op      = rv_pkg::alu_pass_b;
      end
      rv_pkg::opc_branch: begin
        dec_next.branch = 1'b1;
        dec_next.imm    = imm_b;
        dec_next.alu_op = rv_pkg::alu_sub;
        // Only beq, bne and blt
        if (ins.b_fmt.funct3 != 3'b000 && ins.b_fmt.funct3 != 3'b001 &&
            ins.b_fmt.funct3 != 3'b100) begin
          dec_next.illegal = 1'b1;
        end
      end
      rv_pkg::opc_jal: begin
        dec_next.reg_write = 1'b1;
        dec_next.jal       = 1'b1;
        dec_next.imm       = imm_j;
      end
      rv_pkg::opc_jalr: begin
        dec_next.reg_write   = 1'b1;
        dec_next.jalr        = 1'b1;
        dec_next.alu_src_imm = 1'b1;
        dec_next.imm         = imm_i;
        dec_next.illegal     = ins.i_fmt.funct3 != 3'b000;
      end
      default: dec_next.illegal = 1'b1;
    endcase

    // Illegal words keep only their status
    if (dec_next.illegal) begin
      dec_next.reg_write = 1'b0;
      dec_next.branch    = 1'b0;
      dec_next.jal       = 1'b0;
      dec_next.jalr      = 1'b0;
      dec_next.lui       = 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Decode/execute register
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (reset || flush.valid || !hold_valid) begin
      dec_ex.valid     <= 1'b0;
      dec_ex.illegal   <= 1'b0;
      dec_ex.reg_write <= 1'b0;
      dec_ex.branch    <= 1'b0;
      dec_ex.jal       <= 1'b0;
      dec_ex.jalr      <= 1'b0;
      dec_ex.lui       <= 1'b0;
    end else begin
      dec_ex <= dec_next;
    end
  end

endmodule

// ==== hdl/execute_stage.sv ====
`timescale 1ns/100ps

module execute_stage (
  input  logic              bus,
  input  logic              reset,
  input  rv_pkg::dec_ex_t   dec_ex,
  output rv_pkg::ex_wb_t    ex_wb,
  output rv_pkg::redirect_t redirect
);

  logic                        fwd_ok;
  logic                        fwd1;
  logic                        fwd2;
  logic [rv_pkg::xlen-1:0]     op1;
  logic [rv_pkg::xlen-1:0]     op2;
  logic [rv_pkg::xlen-1:0]     alu_b;
  logic [rv_pkg::xlen-1:0]     alu_res;
  logic [rv_pkg::xlen-1:0]     link;
  logic [rv_pkg::xlen-1:0]     result;
  logic [rv_pkg::xlen-1:0]     jalr_sum;
  logic [rv_pkg::pc_width-1:0] pc_plus4;
  logic [rv_pkg::pc_width-1:0] br_target;
  logic                        eq;
  logic                        less;
  logic                        cond_met;

  // Distance 1 bypass from the entry one stage ahead
  assign fwd_ok = ex_wb.valid && ex_wb.reg_write && ex_wb.rd != 5'd0;
  assign fwd1   = fwd_ok && ex_wb.rd == dec_ex.rs1;
  assign fwd2   = fwd_ok && ex_wb.rd == dec_ex.rs2;
  assign op1    = fwd1 ? ex_wb.result : dec_ex.rs1_data;
  assign op2    = fwd2 ? ex_wb.result : dec_ex.rs2_data;
  assign alu_b  = dec_ex.alu_src_imm ? dec_ex.imm : op2;

  // Branches use rs2 here, so one comparator serves slt and blt
  assign eq   = op1 == alu_b;
  assign less = $signed(op1) < $signed(alu_b);

  //////////////////////////////////////////////////////////////////////////
  // ALU and result select
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (dec_ex.alu_op)
      rv_pkg::alu_add:    alu_res = op1 + alu_b;
      rv_pkg::alu_sub:    alu_res = op1 - alu_b;
      rv_pkg::alu_and:    alu_res = op1 & alu_b;
      rv_pkg::alu_or:     alu_res = op1 | alu_b;
      rv_pkg::alu_xor:    alu_res = op1 ^ alu_b;
      rv_pkg::alu_slt:    alu_res = {{(rv_pkg::xlen - 1){1'b0}}, less};
      rv_pkg::alu_sll:    alu_res = op1 << alu_b[4:0];
      rv_pkg::alu_srl:    alu_res = op1 >> alu_b[4:0];
      rv_pkg::alu_pass_b: alu_res = alu_b;
      default:            alu_res = '0;
    endcase
  end

  assign pc_plus4 = dec_ex.pc + 3'd4;
  assign link     = {{(rv_pkg::xlen - rv_pkg::pc_width){1'b0}}, pc_plus4};

  always_comb begin
    if (dec_ex.jal || dec_ex.jalr) begin
      result = link;
    end else if (dec_ex.lui) begin
      result = dec_ex.imm;
    end else begin
      result = alu_res;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Branch decision and redirect
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (dec_ex.branch_cond)
      3'b000:  cond_met = eq;
      3'b001:  cond_met = !eq;
      3'b100:  cond_met = less;
      default: cond_met = 1'b0;
    endcase
  end

  assign jalr_sum  = op1 + dec_ex.imm;
  assign br_target = dec_ex.pc + dec_ex.imm[rv_pkg::pc_width-1:0];

  assign redirect.valid  = dec_ex.valid &&
                           ((dec_ex.branch && cond_met) || dec_ex.jal || dec_ex.jalr);
  // jalr target has bit 0 forced low
  assign redirect.target = dec_ex.jalr ? {jalr_sum[rv_pkg::pc_width-1:1], 1'b0} : br_target;

  // Execute/writeback register
  always_ff @(posedge bus) begin
    if (reset) begin
      ex_wb.valid     <= 1'b0;
      ex_wb.illegal   <= 1'b0;
      ex_wb.reg_write <= 1'b0;
    end else begin
      ex_wb.valid     <= dec_ex.valid;
      ex_wb.illegal   <= dec_ex.valid && dec_ex.illegal;
      ex_wb.reg_write <= dec_ex.valid && dec_ex.reg_write;
      ex_wb.pc        <= dec_ex.pc;
      ex_wb.rd        <= dec_ex.rd;
      ex_wb.result    <= result;
    end
  end

endmodule

// ==== hdl/writeback_stage.sv ====
`timescale 1ns/100ps

module writeback_stage (
  input  logic                    bus,
  input  logic                    reset,
  input  rv_pkg::ex_wb_t          ex_wb,
  output logic                    we,
  output logic [4:0]              waddr,
  output logic [rv_pkg::xlen-1:0] wdata,
  output rv_pkg::retire_t         retire
);

  // Register file write, never to x0
  assign we    = ex_wb.valid && ex_wb.reg_write && !ex_wb.illegal && ex_wb.rd != 5'd0;
  assign waddr = ex_wb.rd;
  assign wdata = ex_wb.result;

  //////////////////////////////////////////////////////////////////////////
  // Retire record, one cycle behind the write
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (reset) begin
      retire.valid     <= 1'b0;
      retire.illegal   <= 1'b0;
      retire.reg_write <= 1'b0;
    end else begin
      retire.valid     <= ex_wb.valid;
      retire.illegal   <= ex_wb.valid && ex_wb.illegal;
      // Reports whether the register really changed
      retire.reg_write <= we;
      retire.pc        <= ex_wb.pc;
      retire.rd        <= ex_wb.rd;
      retire.result    <= ex_wb.result;
    end
  end

endmodule

// ==== hdl/core_top.sv ====
`timescale 1ns/100ps

module core_top (
  input  logic              bus,
  input  logic              reset,
  input  rv_pkg::instr_in_t in,
  input  logic              in_valid,
  output logic              in_ready,
  output rv_pkg::redirect_t redirect,
  output rv_pkg::retire_t   retire
);

  logic [4:0]              raddr1;
  logic [4:0]              raddr2;
  logic [rv_pkg::xlen-1:0] rdata1;
  logic [rv_pkg::xlen-1:0] rdata2;
  logic                    we;
  logic [4:0]              waddr;
  logic [rv_pkg::xlen-1:0] wdata;
  rv_pkg::dec_ex_t         dec_ex;
  rv_pkg::ex_wb_t          ex_wb;

  reg_file i_reg_file (
    .bus    (bus),
    .reset  (reset),
    .raddr1 (raddr1),
    .raddr2 (raddr2),
    .we     (we),
    .waddr  (waddr),
    .wdata  (wdata),
    .rdata1 (rdata1),
    .rdata2 (rdata2)
  );

  // Redirect doubles as the decode flush
  decode_stage i_decode_stage (
    .bus      (bus),
    .reset    (reset),
    .in       (in),
    .in_valid (in_valid),
    .flush    (redirect),
    .rdata1   (rdata1),
    .rdata2   (rdata2),
    .in_ready (in_ready),
    .raddr1   (raddr1),
    .raddr2   (raddr2),
    .dec_ex   (dec_ex)
  );

  execute_stage i_execute_stage (
    .bus      (bus),
    .reset    (reset),
    .dec_ex   (dec_ex),
    .ex_wb    (ex_wb),
    .redirect (redirect)
  );

  writeback_stage i_writeback_stage (
    .bus    (bus),
    .reset  (reset),
    .ex_wb  (ex_wb),
    .we     (we),
    .waddr  (waddr),
    .wdata  (wdata),
    .retire (retire)
  );

endmodule

// ==== testbench/tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock (
  output logic bus,
  output logic reset
);

  // 10 ns period
  initial begin
    bus = 1'b0;
    forever #5 bus = ~bus;
  end

  // Reset held for four rising edges, released away from the edge
  initial begin
    reset = 1'b1;
    repeat (4) @(posedge bus);
    @(negedge bus);
    reset = 1'b0;
  end

endmodule

// ==== testbench/core_asserts.sv ====
`timescale 1ns/100ps

module core_asserts (
  input logic              bus,
  input logic              reset,
  input rv_pkg::instr_in_t in,
  input logic              in_valid,
  input logic              in_ready,
  input rv_pkg::redirect_t redirect,
  input rv_pkg::retire_t   retire
);

  // Offered word stays offered until taken
  assert property (@(posedge bus) disable iff (reset)
    in_valid && !in_ready |=> in_valid)
    else $error("in_valid dropped before the transfer");

  assert property (@(posedge bus) disable iff (reset)
    in_valid && !in_ready |=> $stable(in))
    else $error("instruction payload changed while waiting for in_ready");

  // One-cycle redirect pulse
  assert property (@(posedge bus) disable iff (reset)
    redirect.valid |=> !redirect.valid)
    else $error("redirect.valid high for two cycles in a row");

  // First cycle out of reset still sees an empty pipeline
  assert property (@(posedge bus) $fell(reset) |=> !retire.valid)
    else $error("retire.valid high right after reset");

endmodule

bind core_top core_asserts i_core_asserts (.*);

// ==== testbench/core_tb.sv ====
`timescale 1ns/100ps

module core_tb;

  logic              bus;
  logic              reset;
  rv_pkg::instr_in_t in_word;
  logic              in_valid;
  logic              in_ready;
  rv_pkg::redirect_t redirect_out;
  rv_pkg::retire_t   retire_out;

  // Reference model state
  logic [31:0]         model_regs [0:31];
  rv_pkg::retire_t     exp_q [$];
  bit                  chk_q [$];
  int                  ret_stamps [$];
  logic [15:0]         pc_next;
  int                  cycle;
  int                  last_accept;
  int                  redirects_seen;
  int                  redirects_expected;
  int                  seed;

  tb_clock i_tb_clock (
    .bus   (bus),
    .reset (reset)
  );

  core_top i_core_top (
    .bus      (bus),
    .reset    (reset),
    .in       (in_word),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .redirect (redirect_out),
    .retire   (retire_out)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Failure reporting and compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic stop_run();
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic report_failure(input string what);
    $display("%s", what);
    stop_run();
  endtask

  task automatic field_mismatch(input string name, input logic [31:0] exp,
                                input logic [31:0] got);
    $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, got);
    stop_run();
  endtask

  task automatic check_retire(input rv_pkg::retire_t exp, input rv_pkg::retire_t got,
                              input bit chk_result);
    if (got.valid !== exp.valid) field_mismatch("retire.valid", exp.valid, got.valid);
    if (exp.valid) begin
      if (got.illegal !== exp.illegal) field_mismatch("retire.illegal", exp.illegal, got.illegal);
      if (got.pc !== exp.pc) field_mismatch("retire.pc", exp.pc, got.pc);
      if (got.rd !== exp.rd) field_mismatch("retire.rd", exp.rd, got.rd);
      if (got.reg_write !== exp.reg_write) begin
        field_mismatch("retire.reg_write", exp.reg_write, got.reg_write);
      end
      if (chk_result && got.result !== exp.result) begin
        field_mismatch("retire.result", exp.result, got.result);
      end
    end
  endtask

  task automatic check_redirect(input rv_pkg::redirect_t exp, input rv_pkg::redirect_t got);
    if (got.valid !== exp.valid) field_mismatch("redirect.valid", exp.valid, got.valid);
    if (exp.valid && got.target !== exp.target) begin
      field_mismatch("redirect.target", exp.target, got.target);
    end
  endtask

  task automatic check_ready(input logic exp, input logic got);
    if (got !== exp) field_mismatch("in_ready", exp, got);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Encoders and the RV32I reference rules
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [2:0] op_funct3(input rv_pkg::alu_op_e op);
    case (op)
      rv_pkg::alu_sll: return 3'b001;
      rv_pkg::alu_slt: return 3'b010;
      rv_pkg::alu_xor: return 3'b100;
      rv_pkg::alu_srl: return 3'b101;
      rv_pkg::alu_or:  return 3'b110;
      rv_pkg::alu_and: return 3'b111;
      default:         return 3'b000;
    endcase
  endfunction

  function automatic logic [31:0] ref_alu(input rv_pkg::alu_op_e op, input logic [31:0] a,
                                          input logic [31:0] b);
    case (op)
      rv_pkg::alu_sub: return a - b;
      rv_pkg::alu_and: return a & b;
      rv_pkg::alu_or:  return a | b;
      rv_pkg::alu_xor: return a ^ b;
      rv_pkg::alu_slt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      rv_pkg::alu_sll: return a << b[4:0];
      rv_pkg::alu_srl: return a >> b[4:0];
      default:         return a + b;
    endcase
  endfunction

  function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                        input logic [4:0] rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Fetch side and monitors
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge bus) cycle <= cycle + 1;

  always @(negedge bus) begin
    if (!reset && redirect_out.valid) redirects_seen++;
    if (!reset && retire_out.valid) begin
      if (exp_q.size() == 0) report_failure("An instruction retired that was never expected");
      ret_stamps.push_back(cycle);
      check_retire(exp_q.pop_front(), retire_out, chk_q.pop_front());
    end
  end

  // Called at a falling edge, returns at the falling edge after the transfer
  task automatic send(input logic [31:0] word);
    int waited;
    waited = 0;
    in_word.instr = word;
    in_word.pc = pc_next;
    in_valid = 1'b1;
    while (!in_ready) begin
      @(negedge bus);
      waited++;
      if (waited > 50) report_failure("Timed out waiting for in_ready");
    end
    @(posedge bus);
    @(negedge bus);
    last_accept = cycle;
    pc_next = pc_next + 16'd4;
  endtask

  task automatic idle(input int n);
    in_valid = 1'b0;
    repeat (n) @(negedge bus);
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      @(negedge bus);
      waited++;
      if (waited > 50) report_failure("Timed out waiting for expected retires");
    end
  endtask

  // Model update happens here, so squashed words never reach it
  task automatic push_expect(input logic [15:0] pc, input logic [4:0] rd, input bit wr,
                             input logic [31:0] result, input bit illegal, input bit chk);
    rv_pkg::retire_t r;
    r = '0;
    r.valid = 1'b1;
    r.illegal = illegal;
    r.pc = pc;
    r.rd = rd;
    r.reg_write = wr && !illegal && rd != 5'd0;
    r.result = result;
    if (r.reg_write) model_regs[rd] = result;
    exp_q.push_back(r);
    chk_q.push_back(chk);
  endtask

  task automatic do_r(input rv_pkg::alu_op_e op, input logic [4:0] rd, input logic [4:0] rs1,
                      input logic [4:0] rs2);
    logic [15:0] p;
    logic [6:0]  f7;
    p = pc_next;
    f7 = (op == rv_pkg::alu_sub) ? 7'h20 : 7'h00;
    send({f7, rs2, rs1, op_funct3(op), rd, 7'b0110011});
    push_expect(p, rd, 1'b1, ref_alu(op, model_regs[rs1], model_regs[rs2]), 1'b0, 1'b1);
  endtask

  task automatic do_i(input rv_pkg::alu_op_e op, input logic [4:0] rd, input logic [4:0] rs1,
                      input logic [11:0] imm);
    logic [15:0] p;
    p = pc_next;
    send({imm, rs1, op_funct3(op), rd, 7'b0010011});
    push_expect(p, rd, 1'b1, ref_alu(op, model_regs[rs1], {{20{imm[11]}}, imm}), 1'b0, 1'b1);
  endtask

  task automatic do_lui(input logic [4:0] rd, input logic [19:0] imm);
    logic [15:0] p;
    p = pc_next;
    send({imm, rd, 7'b0110111});
    push_expect(p, rd, 1'b1, {imm, 12'h000}, 1'b0, 1'b1);
  endtask

  // Younger word goes in behind the transfer, then a landing word at the new pc
  task automatic finish_transfer(input bit taken, input logic [15:0] target);
    rv_pkg::redirect_t exp;
    logic [15:0]       p;
    p = pc_next;
    send({12'd1, 5'd30, 3'b000, 5'd30, 7'b0010011});
    exp.valid = taken;
    exp.target = target;
    check_redirect(exp, redirect_out);
    in_valid = 1'b0;
    if (taken) begin
      redirects_expected++;
      pc_next = target;
    end else begin
      push_expect(p, 5'd30, 1'b1, model_regs[30] + 32'd1, 1'b0, 1'b1);
    end
    @(negedge bus);
    do_i(rv_pkg::alu_add, 5'd31, 5'd31, 12'd1);
    idle(2);
    wait_drain();
  endtask

  task automatic branch_case(input logic [2:0] f3, input logic [4:0] rs1,
                             input logic [4:0] rs2, input logic [12:0] imm);
    logic [15:0] p;
    logic [31:0] word;
    bit          taken;
    p = pc_next;
    word = enc_b(f3, rs1, rs2, imm);
    case (f3)
      3'b000:  taken = model_regs[rs1] == model_regs[rs2];
      3'b001:  taken = model_regs[rs1] != model_regs[rs2];
      default: taken = $signed(model_regs[rs1]) < $signed(model_regs[rs2]);
    endcase
    send(word);
    push_expect(p, word[11:7], 1'b0, 32'd0, 1'b0, 1'b0);
    finish_transfer(taken, p + {{3{imm[12]}}, imm});
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_reset();
    rv_pkg::redirect_t quiet;
    rv_pkg::retire_t   none;
    int                waited;
    waited = 0;
    quiet = '0;
    none = '0;
    while (reset) begin
      check_ready(1'b0, in_ready);
      @(negedge bus);
      waited++;
      if (waited > 50) report_failure("Timed out waiting for reset release");
    end
    repeat (3) begin
      check_retire(none, retire_out, 1'b0);
      check_redirect(quiet, redirect_out);
      @(negedge bus);
    end
    ret_stamps.delete();
    do_i(rv_pkg::alu_add, 5'd30, 5'd0, 12'd0);
    idle(1);
    wait_drain();
    if (ret_stamps[0] - last_accept != 3) begin
      report_failure("First retire not 3 cycles after its transfer");
    end
    do_i(rv_pkg::alu_add, 5'd31, 5'd0, 12'd0);
    idle(2);
  endtask

  task automatic test_alu();
    rv_pkg::alu_op_e r_ops [8];
    rv_pkg::alu_op_e i_ops [5];
    r_ops = '{rv_pkg::alu_add, rv_pkg::alu_sub, rv_pkg::alu_and, rv_pkg::alu_or,
              rv_pkg::alu_xor, rv_pkg::alu_slt, rv_pkg::alu_sll, rv_pkg::alu_srl};
    i_ops = '{rv_pkg::alu_add, rv_pkg::alu_and, rv_pkg::alu_or, rv_pkg::alu_xor,
              rv_pkg::alu_slt};
    for (int r = 1; r <= 8; r++) begin
      do_lui(r[4:0], 20'($random(seed)));
      idle(2);
      do_i(rv_pkg::alu_add, r[4:0], r[4:0], 12'($random(seed)));
      idle(2);
    end
    foreach (r_ops[k]) begin
      do_r(r_ops[k], 5'(9 + k), 5'(1 + ($unsigned($random(seed)) % 8)),
           5'(1 + ($unsigned($random(seed)) % 8)));
      idle(2);
    end
    foreach (i_ops[k]) begin
      do_i(i_ops[k], 5'(17 + k), 5'(1 + ($unsigned($random(seed)) % 8)), 12'($random(seed)));
      idle(2);
    end
    wait_drain();
  endtask

  task automatic test_forwarding();
    ret_stamps.delete();
    do_i(rv_pkg::alu_add, 5'd5, 5'd5, 12'h123);
    do_r(rv_pkg::alu_add, 5'd6, 5'd5, 5'd5);
    do_r(rv_pkg::alu_xor, 5'd7, 5'd6, 5'd5);
    do_r(rv_pkg::alu_sub, 5'd8, 5'd7, 5'd6);
    do_r(rv_pkg::alu_or, 5'd5, 5'd8, 5'd7);
    do_r(rv_pkg::alu_sll, 5'd9, 5'd5, 5'd8);
    do_r(rv_pkg::alu_srl, 5'd6, 5'd9, 5'd5);
    do_i(rv_pkg::alu_slt, 5'd7, 5'd6, 12'h7ff);
    idle(1);
    wait_drain();
    for (int k = 1; k < ret_stamps.size(); k++) begin
      if (ret_stamps[k] != ret_stamps[k-1] + 1) begin
        report_failure("Forwarding chain did not retire back to back");
      end
    end
    if (ret_stamps.size() != 8) report_failure("Forwarding chain lost an instruction");
  endtask

  task automatic test_branches();
    do_i(rv_pkg::alu_add, 5'd22, 5'd0, 12'd5);
    do_i(rv_pkg::alu_add, 5'd23, 5'd0, 12'd5);
    do_i(rv_pkg::alu_add, 5'd24, 5'd0, 12'hffd);
    idle(2);
    branch_case(3'b000, 5'd22, 5'd23, 13'd32);
    branch_case(3'b000, 5'd22, 5'd24, 13'd32);
    branch_case(3'b001, 5'd22, 5'd24, 13'h1ff4);
    branch_case(3'b001, 5'd22, 5'd23, 13'd16);
    branch_case(3'b100, 5'd24, 5'd22, 13'd64);
    branch_case(3'b100, 5'd22, 5'd24, 13'd64);
  endtask

  task automatic test_jumps();
    logic [15:0] p;
    logic [31:0] sum;
    p = pc_next;
    send(enc_j(5'd20, 21'd256));
    push_expect(p, 5'd20, 1'b1, {16'h0, p + 16'd4}, 1'b0, 1'b1);
    finish_transfer(1'b1, p + 16'd256);
    // Odd sum so that bit 0 of the target gets cleared
    do_i(rv_pkg::alu_add, 5'd21, 5'd0, 12'h301);
    idle(2);
    p = pc_next;
    sum = model_regs[21] + 32'h7e;
    send({12'h07e, 5'd21, 3'b000, 5'd21, 7'b1100111});
    push_expect(p, 5'd21, 1'b1, {16'h0, p + 16'd4}, 1'b0, 1'b1);
    finish_transfer(1'b1, {sum[15:1], 1'b0});
  endtask

  task automatic test_x0_illegal();
    logic [15:0] p;
    do_i(rv_pkg::alu_add, 5'd0, 5'd3, 12'd5);
    do_r(rv_pkg::alu_add, 5'd10, 5'd0, 5'd0);
    idle(2);
    p = pc_next;
    // Load opcode is outside the supported set
    send({12'h004, 5'd1, 3'b010, 5'd11, 7'b0000011});
    push_expect(p, 5'd11, 1'b0, 32'd0, 1'b1, 1'b0);
    do_r(rv_pkg::alu_add, 5'd12, 5'd11, 5'd0);
    do_r(rv_pkg::alu_or, 5'd13, 5'd0, 5'd3);
    idle(2);
    wait_drain();
  endtask

  initial begin
    in_word = '0;
    in_valid = 1'b0;
    cycle = 0;
    last_accept = 0;
    redirects_seen = 0;
    redirects_expected = 0;
    seed = 57502;
    pc_next = 16'h0100;
    for (int r = 0; r < 32; r++) model_regs[r] = '0;
    @(negedge bus);
    test_reset();
    test_alu();
    test_forwarding();
    test_branches();
    test_jumps();
    test_x0_illegal();
    idle(4);
    if (redirects_seen != redirects_expected) begin
      $display("Redirect count %0d does not match the expected %0d", redirects_seen,
               redirects_expected);
      stop_run();
    end else if (exp_q.size() != 0) begin
      report_failure("Expected retires still pending at the end of the run");
    end else begin
      $display("Test OK");
      $finish;
    end
  end

endmodule

// ==== build.f ====
hdl/rv_pkg.sv
hdl/reg_file.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/writeback_stage.sv
hdl/core_top.sv
testbench/tb_clock.sv
testbench/core_asserts.sv
testbench/core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the core testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module core_tb -f build.f -Mdir obj_dir -o core_sim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/core_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "Test OK" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation did not report success"
  exit 1
fi
